// ==== cipher_defs.svh ====
`ifndef CIPHER_DEFS_SVH
`define CIPHER_DEFS_SVH

// Seed, data and keystream word width
`define CIPHER_WORD_W 64

// Command code width
`define CIPHER_CMD_W 2

// Accepted-word counter width
`define CIPHER_CNT_W 16

`endif

// ==== cipher_output.sv ====
`timescale 1ns/1ps

module cipher_output (
    input  logic              clk,        // Clock
    input  logic              rst_n,      // Sync reset, active low
    input  logic              op_valid,   // Operation pending
    input  logic              op_raw,     // Pass keystream unchanged
    input  cipher_pkg::word_t op_data,    // Message word
    input  cipher_pkg::word_t keystream,  // Live LFSR word
    output cipher_pkg::word_t data_out,   // Result word
    output logic              out_valid   // Result strobe
);

    cipher_pkg::word_t result;  // Combined word

    // Keystream here is the word held since the command edge
    assign result = op_raw ? keystream : (op_data ^ keystream);

    always_ff @(posedge clk) begin  // Valid strobe
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= op_valid;  // Single cycle per operation
        end
    end

    always_ff @(posedge clk) begin  // Result register
        if (op_valid) begin
            data_out <= result;  // Held until next strobe
        end
    end

endmodule

// ==== cipher_pkg.sv ====
`include "cipher_defs.svh"

package cipher_pkg;

    // Command codes on the cmd input
    typedef enum logic [`CIPHER_CMD_W-1:0] {
        CMD_NOP  = 2'd0,    // Idle cycle
        CMD_SEED = 2'd1,    // cmd_data is the LFSR seed
        CMD_ENC  = 2'd2,    // cmd_data XOR keystream
        CMD_RAW  = 2'd3     // Keystream word as is
    } cmd_e;

    // Seed, data and keystream word
    typedef logic [`CIPHER_WORD_W-1:0] word_t;

endpackage

// ==== cmd_decode.sv ====
`timescale 1ns/1ps
`include "cipher_defs.svh"

module cmd_decode (
    input  logic                     clk,           // Clock
    input  logic                     rst_n,         // Sync reset, active low
    input  cipher_pkg::cmd_e         cmd,           // Command code
    input  cipher_pkg::word_t        cmd_data,      // Seed or message word
    input  logic                     ks_valid,      // Keystream running
    output logic                     start,         // LFSR start strobe
    output cipher_pkg::word_t        message_seed,  // Seed to the LFSR
    output logic                     op_valid,      // Registered operation pending
    output logic                     op_raw,        // Raw keystream, no XOR
    output cipher_pkg::word_t        op_data,       // Registered message word
    output logic                     cmd_reject,    // Early command pulse
    output logic [`CIPHER_CNT_W-1:0] word_count     // Accepted commands
);

    logic ks_cmd;      // Command needs keystream
    logic accept;      // Keystream command with generator running
    logic reject;      // Keystream command too early
    logic is_raw;      // Raw keystream request

    // LFSR ignores start once it runs, so a late seed has no effect
    assign start        = (cmd == cipher_pkg::CMD_SEED);
    assign message_seed = cmd_data;  // Seed rides on the data bus

    assign is_raw = (cmd == cipher_pkg::CMD_RAW);
    assign ks_cmd = (cmd == cipher_pkg::CMD_ENC) || is_raw;
    assign accept = ks_cmd && ks_valid;
    assign reject = ks_cmd && !ks_valid;

    always_ff @(posedge clk) begin  // Control registers
        if (!rst_n) begin
            op_valid   <= 1'b0;
            cmd_reject <= 1'b0;
            word_count <= '0;
        end else begin
            op_valid   <= accept;  // One cycle per accepted command
            cmd_reject <= reject;  // One cycle per early command
            if (accept) begin
                word_count <= word_count + 1'b1;  // Wraps at full scale
            end
        end
    end

    always_ff @(posedge clk) begin  // Operation payload
        if (accept) begin
            op_data <= cmd_data;
            op_raw  <= is_raw;
        end
    end

    // Hold payload between accepts so the output stage sees stable values
    // until the next operation is registered

endmodule

// ==== lfsr.sv ====
`timescale 1ns/1ps

module lfsr (
    input  logic              clk,           // Clock
    input  logic              rst_n,         // Sync reset, active low
    input  logic              start,         // Seed present, leave init
    input  cipher_pkg::word_t message_seed,  // Seed value
    output cipher_pkg::word_t lfsr,          // Current keystream word
    output logic              valid          // Generator running
);

    localparam logic [1:0] ST_INIT    = 2'h0;  // Reloading the seed
    localparam logic [1:0] ST_FIRST   = 2'h1;  // First shift, not yet valid
    localparam logic [1:0] ST_WORKING = 2'h2;  // Free running

    logic [1:0] state;       // Current state
    logic [1:0] next_state;  // Next state
    logic       load_seed;   // Take message_seed this edge
    logic       load_lfsr;   // Shift this edge
    logic       feedback;    // New bit 0

    always_ff @(posedge clk) begin  // State register
        if (!rst_n) begin
            state <= ST_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin  // Next state
        next_state = state;
        case (state)
            ST_INIT: begin
                if (start) begin
                    next_state = ST_FIRST;  // Seed is loaded on this edge
                end
            end
            ST_FIRST: begin
                next_state = ST_WORKING;
            end
            ST_WORKING: begin
                next_state = ST_WORKING;  // Runs until reset
            end
            default: begin
                next_state = ST_INIT;  // Unused code, recover
            end
        endcase
    end

    always_comb begin  // State decode
        load_seed = 1'b0;
        load_lfsr = 1'b0;
        valid     = 1'b0;
        case (state)
            ST_INIT: begin
                load_seed = 1'b1;  // Track the seed input every edge
            end
            ST_FIRST: begin
                load_lfsr = 1'b1;
            end
            ST_WORKING: begin
                load_lfsr = 1'b1;
                valid     = 1'b1;  // Keystream usable
            end
            default: begin
                load_seed = 1'b0;
            end
        endcase
    end

    // XNOR of taps 63, 62, 60, 59
    assign feedback = ~(lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59]);

    always_ff @(posedge clk) begin  // Shift register
        if (load_seed) begin
            lfsr <= message_seed;
        end else if (load_lfsr) begin
            lfsr <= {lfsr[62:0], feedback};  // Shift left, new bit in at 0
        end
    end

endmodule

// ==== lfsr_cipher.sv ====
`timescale 1ns/1ps
`include "cipher_defs.svh"

module lfsr_cipher (
    input  logic                     clk,         // Clock
    input  logic                     rst_n,       // Sync reset, active low
    input  cipher_pkg::cmd_e         cmd,         // Command code
    input  cipher_pkg::word_t        cmd_data,    // Seed or message word
    output cipher_pkg::word_t        data_out,    // Cipher or keystream word
    output logic                     out_valid,   // Result strobe
    output logic                     cmd_reject,  // Early command pulse
    output logic [`CIPHER_CNT_W-1:0] word_count   // Accepted commands
);

    logic              start;         // Seed command seen
    cipher_pkg::word_t message_seed;  // Seed to LFSR
    cipher_pkg::word_t ks_word;       // Keystream word
    logic              ks_valid;      // Generator running
    logic              op_valid;      // Decode to output strobe
    logic              op_raw;        // Raw request flag
    cipher_pkg::word_t op_data;       // Registered message

    cmd_decode decode_inst (  // Decode stage
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .cmd_data     (cmd_data),
        .ks_valid     (ks_valid),
        .start        (start),
        .message_seed (message_seed),
        .op_valid     (op_valid),
        .op_raw       (op_raw),
        .op_data      (op_data),
        .cmd_reject   (cmd_reject),
        .word_count   (word_count)
    );

    lfsr lfsr_inst (  // Execute stage
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .message_seed (message_seed),
        .lfsr         (ks_word),
        .valid        (ks_valid)
    );

    cipher_output output_inst (  // Result stage
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op_raw    (op_raw),
        .op_data   (op_data),
        .keystream (ks_word),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

endmodule

// ==== lfsr_cipher_checker.sv ====
`timescale 1ns/1ps
`include "cipher_defs.svh"

module lfsr_cipher_checker (
    input logic                     clk,         // Clock
    input logic                     rst_n,       // Sync reset, active low
    input cipher_pkg::cmd_e         cmd,         // Command code at the DUT
    input logic                     ks_valid,    // Generator running
    input logic                     out_valid,   // Result strobe
    input logic                     cmd_reject,  // Early command pulse
    input logic [`CIPHER_CNT_W-1:0] word_count   // Accepted commands
);

    int   error_count = 0;  // Failed assertions so far
    logic ks_cmd;           // Command needs keystream
    logic accept_cmd;       // Keystream command while running
    logic early_cmd;        // Keystream command before running

    assign ks_cmd     = (cmd == cipher_pkg::CMD_ENC) || (cmd == cipher_pkg::CMD_RAW);
    assign accept_cmd = ks_cmd && ks_valid;
    assign early_cmd  = ks_cmd && !ks_valid;

    // Result strobe lags the accepting edge by two edges
    out_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(accept_cmd, 2))
    else begin
        $error("out_valid is not two edges after an accepted command");
        error_count++;
    end

    reject_delay: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_reject == $past(early_cmd))  // One edge after an early command
    else begin
        $error("cmd_reject is not one edge after an early command");
        error_count++;
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && cmd_reject))  // Strobes are unknown before the first reset edge
    else begin
        $error("out_valid and cmd_reject are high together");
        error_count++;
    end

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !cmd_reject && word_count == '0))
    else begin
        $error("outputs not cleared by reset");
        error_count++;
    end

endmodule

bind lfsr_cipher lfsr_cipher_checker checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .ks_valid   (ks_valid),
    .out_valid  (out_valid),
    .cmd_reject (cmd_reject),
    .word_count (word_count)
);

// ==== lfsr_cipher_tb.sv ====
`timescale 1ns/1ps
`include "cipher_defs.svh"

module lfsr_cipher_tb;

    localparam int RESET_CYCLES   = 10;   // Reset length in clocks
    localparam int NOP_CYCLES     = 6;    // Idle cycles after reset
    localparam int EARLY_CMDS     = 4;    // Keystream commands before the seed
    localparam int RAW_RUN        = 20;   // Back-to-back raw requests
    localparam int MIX_RUN        = 100;  // Random mixed commands
    localparam int RESEED_RUN     = 20;   // Commands after the ignored seed
    localparam int DRAIN_CYCLES   = 4;    // Pipeline empties
    localparam int TOTAL_CMDS     = NOP_CYCLES + EARLY_CMDS + 2 + RAW_RUN + MIX_RUN
                                    + 1 + RESEED_RUN + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_CMDS + 50;

    logic                     clk = 1'b0;
    logic                     rst_n;
    cipher_pkg::cmd_e         cmd;
    cipher_pkg::word_t        cmd_data;
    cipher_pkg::word_t        data_out;
    logic                     out_valid;
    logic                     cmd_reject;
    logic [`CIPHER_CNT_W-1:0] word_count;

    int                cycle_count    = 0;     // Timeout counter
    int                edge_count     = 0;     // Edges since reset release
    int                seed_edge      = 0;     // Edge of the accepted seed
    bit                seeded         = 1'b0;  // Model generator started
    cipher_pkg::word_t seed_word      = '0;
    int                accepted_count = 0;
    bit                exp_valid      = 1'b0;  // Expected out_valid this cycle
    bit                exp_reject     = 1'b0;  // Expected cmd_reject this cycle
    bit                acc_prev       = 1'b0;  // Accept seen at the last edge
    cipher_pkg::word_t exp_q[$];               // Expected output words

    lfsr_cipher lfsr_cipher_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_data   (cmd_data),
        .data_out   (data_out),
        .out_valid  (out_valid),
        .cmd_reject (cmd_reject),
        .word_count (word_count)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // One step, XNOR of bits 63 62 60 59 into bit 0
    function automatic cipher_pkg::word_t next_ks(input cipher_pkg::word_t w);
        logic fb;
        fb = ~(w[63] ^ w[62] ^ w[60] ^ w[59]);
        return {w[62:0], fb};
    endfunction

    function automatic cipher_pkg::word_t ks_after(input cipher_pkg::word_t seed,
                                                   input int steps);
        cipher_pkg::word_t w;
        w = seed;
        for (int i = 0; i < steps; i++) begin
            w = next_ks(w);
        end
        return w;
    endfunction

    function automatic cipher_pkg::word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    task automatic send_cmd(input cipher_pkg::cmd_e c, input cipher_pkg::word_t d);
        @(posedge clk);
        cmd      <= c;
        cmd_data <= d;
    endtask

    always @(posedge clk) begin : model  // Sees the values the DUT samples
        cipher_pkg::word_t k_word;
        if (!rst_n) begin
            edge_count     = 0;
            seeded         = 1'b0;
            accepted_count = 0;
            exp_valid      = 1'b0;
            exp_reject     = 1'b0;
            acc_prev       = 1'b0;
            exp_q.delete();
        end else begin
            edge_count = edge_count + 1;
            exp_valid  = acc_prev;  // Result one edge after acceptance
            acc_prev   = 1'b0;
            exp_reject = 1'b0;
            if (cmd == cipher_pkg::CMD_SEED && !seeded) begin
                seeded    = 1'b1;
                seed_word = cmd_data;
                seed_edge = edge_count;
            end else if (cmd == cipher_pkg::CMD_ENC || cmd == cipher_pkg::CMD_RAW) begin
                if (seeded && edge_count >= seed_edge + 2) begin
                    k_word = ks_after(seed_word, edge_count - seed_edge);
                    exp_q.push_back((cmd == cipher_pkg::CMD_RAW) ? k_word
                                                                 : (cmd_data ^ k_word));
                    acc_prev       = 1'b1;
                    accepted_count = accepted_count + 1;
                end else begin
                    exp_reject = 1'b1;  // Generator not yet running
                end
            end
        end
    end

    always @(negedge clk) begin : monitor  // Outputs settled mid-cycle
        cipher_pkg::word_t exp_word;
        if (rst_n) begin
            assert (out_valid == exp_valid) else fail_run($sformatf(
                "ERROR at %0t: out_valid %b, expected %b", $time, out_valid, exp_valid));
            assert (cmd_reject == exp_reject) else fail_run($sformatf(
                "ERROR at %0t: cmd_reject %b, expected %b", $time, cmd_reject, exp_reject));
            assert (word_count == accepted_count) else fail_run($sformatf(
                "ERROR at %0t: word_count %0d, expected %0d", $time, word_count,
                accepted_count));
            if (out_valid && exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                assert (data_out == exp_word) else fail_run($sformatf(
                    "ERROR at %0t: data_out %h, expected %h", $time, data_out, exp_word));
            end
        end
        assert (lfsr_cipher_inst.checker_inst.error_count == 0) else
            fail_run("A timing assertion in the checker failed");
    end

    always @(posedge clk) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, the test did not finish",
                               cycle_count));
        end
    end

    initial begin : stimulus
        int pick;
        void'($urandom(32'h98cd));
        rst_n    = 1'b0;
        cmd      = cipher_pkg::CMD_NOP;
        cmd_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (NOP_CYCLES) send_cmd(cipher_pkg::CMD_NOP, '0);  // Idle after reset
        for (int i = 0; i < EARLY_CMDS; i++) begin  // Before any seed
            send_cmd((i % 2) ? cipher_pkg::CMD_RAW : cipher_pkg::CMD_ENC, rand_word());
        end
        send_cmd(cipher_pkg::CMD_SEED, rand_word());
        send_cmd(cipher_pkg::CMD_ENC, rand_word());  // Generator in first state
        repeat (RAW_RUN) send_cmd(cipher_pkg::CMD_RAW, rand_word());
        for (int i = 0; i < MIX_RUN; i++) begin
            pick = $urandom % 3;
            case (pick)
                0:       send_cmd(cipher_pkg::CMD_NOP, rand_word());
                1:       send_cmd(cipher_pkg::CMD_ENC, rand_word());
                default: send_cmd(cipher_pkg::CMD_RAW, rand_word());
            endcase
        end
        send_cmd(cipher_pkg::CMD_SEED, rand_word());  // Running, no effect
        for (int i = 0; i < RESEED_RUN; i++) begin
            send_cmd((i % 2) ? cipher_pkg::CMD_ENC : cipher_pkg::CMD_RAW, rand_word());
        end
        repeat (DRAIN_CYCLES) send_cmd(cipher_pkg::CMD_NOP, '0);
        @(negedge clk);
        assert (word_count == accepted_count) else fail_run($sformatf(
            "ERROR at %0t: final word_count %0d, expected %0d", $time, word_count,
            accepted_count));
        assert (exp_q.size() == 0) else
            fail_run("Some accepted commands never produced an output word");
        if (lfsr_cipher_inst.checker_inst.error_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_run("The timing checker reported failures");
        end
    end

endmodule

// ==== list.f ====
+incdir+.
cipher_pkg.sv
lfsr.sv
cmd_decode.sv
cipher_output.sv
lfsr_cipher.sv
lfsr_cipher_checker.sv
lfsr_cipher_tb.sv
